// ==== logic/decode_params.svh ====
// Widths, ISA field positions and class bit positions shared by the decode packages and RTL
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// ==========================================================================
// Datapath and instruction format
// ==========================================================================

`define DEC_XLEN          32
`define DEC_ILEN          32
`define DEC_OPC_BITS      6
`define DEC_REG_BITS      6

// Field positions inside the instruction word
`define DEC_OPC_LSB       0
`define DEC_RD_LSB        6
`define DEC_RS1_LSB       12
`define DEC_RS2_LSB       18

// Register file shape. The top eight registers belong to machine mode only
`define DEC_NUM_REGS      64
`define DEC_PRIV_REG_BASE 56

// ==========================================================================
// Operation class vector, one flag per bit
// ==========================================================================

`define DEC_CLS_ALU       0
`define DEC_CLS_MUL       1
`define DEC_CLS_DIV       2
`define DEC_CLS_LOAD      3
`define DEC_CLS_STORE     4
`define DEC_CLS_MEM       5
`define DEC_CLS_BRANCH    6
`define DEC_CLS_JUMP      7
`define DEC_CLS_CSR       8
`define DEC_CLS_FENCE     9
`define DEC_CLS_SYS       10
`define DEC_NUM_CLASSES   11

`endif

// ==== logic/isa_pkg.sv ====
// Instruction-set types and field extractors, imported by every decoder that looks at instr bits
`include "decode_params.svh"

package isa_pkg;

	// Opcode values of the toy ISA
	// Anything outside this list decodes as unimplemented
	typedef enum logic [`DEC_OPC_BITS-1:0] {
		OP_NOP   = 6'd0,
		OP_ADD   = 6'd1,
		OP_ADDI  = 6'd2,
		OP_AND   = 6'd3,
		OP_OR    = 6'd4,
		OP_MUL   = 6'd5,
		OP_DIV   = 6'd6,
		OP_LOAD  = 6'd7,
		OP_STORE = 6'd8,
		OP_BEQ   = 6'd9,
		OP_JSR   = 6'd10,
		OP_CSR   = 6'd11,
		OP_FENCE = 6'd12,
		OP_SYS   = 6'd13
	} opcode_t;

	typedef logic [`DEC_REG_BITS-1:0] reg_num_t;
	typedef logic [`DEC_ILEN-1:0]     instr_t;
	typedef logic [`DEC_XLEN-1:0]     value_t;

	// User mode is the reset-safe encoding
	typedef enum logic {
		MODE_USER    = 1'b0,
		MODE_MACHINE = 1'b1
	} op_mode_t;

	// ==========================================================================
	// Field extractors
	// ==========================================================================

	// The cast keeps undefined opcode values; callers fall into their default arm
	function automatic opcode_t get_opcode(input instr_t i);
		return opcode_t'(i[`DEC_OPC_LSB +: `DEC_OPC_BITS]);
	endfunction

	function automatic reg_num_t get_rd(input instr_t i);
		return i[`DEC_RD_LSB +: `DEC_REG_BITS];
	endfunction

	function automatic reg_num_t get_rs1(input instr_t i);
		return i[`DEC_RS1_LSB +: `DEC_REG_BITS];
	endfunction

	function automatic reg_num_t get_rs2(input instr_t i);
		return i[`DEC_RS2_LSB +: `DEC_REG_BITS];
	endfunction

endpackage

// ==== logic/decode_pkg.sv ====
// Decode result types, imported by the class decoder and the decode stage top level
`include "decode_params.svh"

package decode_pkg;

	// Fault cause reported with each decoded slot
	// Unimplemented outranks a bad register when both apply
	typedef enum logic [1:0] {
		FLT_NONE   = 2'd0,
		FLT_BADREG = 2'd1,
		FLT_UNIMP  = 2'd2
	} cause_t;

	// One flag per operation class, indexed by the DEC_CLS_* positions
	typedef logic [`DEC_NUM_CLASSES-1:0] op_class_t;

	// MEM rides along with LOAD and STORE, so it is masked off when
	// counting how many primary classes an opcode claims
	localparam op_class_t CLS_MEM_MASK = op_class_t'(1) << `DEC_CLS_MEM;

	// Value of the class vector for a bubble or an unimplemented opcode
	localparam op_class_t CLS_NONE = '0;

endpackage

// ==== logic/reg_fields_if.sv ====
// Register field bundle between the register decoder and the decode stage output register
`timescale 1ns/1ps

interface reg_fields_if import isa_pkg::*; ();

	// Register numbers, zero when the opcode does not use the field
	reg_num_t rd;
	reg_num_t rs1;
	reg_num_t rs2;

	// Field is used by the opcode
	logic     has_rd;
	logic     has_rs1;
	logic     has_rs2;

	// Field names register zero, which reads as zero
	logic     rd_z;
	logic     rs1_z;
	logic     rs2_z;

	// A used field names a privileged register outside machine mode
	logic     bad_reg;

	modport source (
		output rd, rs1, rs2,
		output has_rd, has_rs1, has_rs2,
		output rd_z, rs1_z, rs2_z,
		output bad_reg
	);

	modport sink (
		input rd, rs1, rs2,
		input has_rd, has_rs1, has_rs2,
		input rd_z, rs1_z, rs2_z,
		input bad_reg
	);

endinterface

// ==== logic/decode_regs.sv ====
// Register field decoder; instantiated by the decode stage to pick rd, rs1, rs2 and check privilege
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_regs import isa_pkg::*; (
	input  instr_t          instr,
	input  op_mode_t        mode,
	reg_fields_if.source    regs
);

	opcode_t  op;
	logic     use_rd;
	logic     use_rs1;
	logic     use_rs2;
	reg_num_t rd_num;
	reg_num_t rs1_num;
	reg_num_t rs2_num;

	// Privileged window runs from the base up to the last register
	function automatic logic is_priv(input reg_num_t r);
		return int'(r) >= `DEC_PRIV_REG_BASE;
	endfunction

	assign op = get_opcode(instr);

	// ==========================================================================
	// Register use per opcode
	// ==========================================================================

	always_comb begin
		use_rd  = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (op)
			OP_ADD, OP_AND, OP_OR, OP_MUL, OP_DIV: begin
				use_rd  = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			OP_ADDI, OP_LOAD, OP_CSR: begin
				use_rd  = 1'b1;
				use_rs1 = 1'b1;
			end
			OP_STORE, OP_BEQ: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			OP_JSR: use_rd = 1'b1;
			// NOP, FENCE, SYS and all unimplemented opcodes read no registers
			default: ;
		endcase
	end

	// Unused fields are forced to zero so downstream sees register zero
	assign rd_num  = use_rd  ? get_rd(instr)  : '0;
	assign rs1_num = use_rs1 ? get_rs1(instr) : '0;
	assign rs2_num = use_rs2 ? get_rs2(instr) : '0;

	assign regs.rd      = rd_num;
	assign regs.rs1     = rs1_num;
	assign regs.rs2     = rs2_num;
	assign regs.has_rd  = use_rd;
	assign regs.has_rs1 = use_rs1;
	assign regs.has_rs2 = use_rs2;
	assign regs.rd_z    = (rd_num == '0);
	assign regs.rs1_z   = (rs1_num == '0);
	assign regs.rs2_z   = (rs2_num == '0);

	// A zeroed field can never hit the privileged window, so only used fields count
	assign regs.bad_reg = (mode == MODE_USER)
		&& (is_priv(rd_num) || is_priv(rs1_num) || is_priv(rs2_num));

	// Machine mode may touch every register, so the fault must stay quiet there
	a_no_badreg_machine: assert final (!(regs.bad_reg && mode == MODE_MACHINE))
		else $error("decode_regs: bad_reg raised in machine mode");

endmodule

// ==== logic/decode_imm.sv ====
// Immediate decoder; instantiated by the decode stage to build the sign-extended or pc-relative value
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_imm import isa_pkg::*; (
	input  instr_t instr,
	input  value_t pc,
	output value_t imm,
	output logic   has_imm
);

	// Every immediate runs up to the top instruction bit and starts on a
	// field boundary. The I form sits in the rs2 slot, the S/B form just
	// above it, and the J form covers rs1 and rs2 together
	localparam int IMM_I_LSB = `DEC_RS2_LSB;
	localparam int IMM_S_LSB = `DEC_RS2_LSB + `DEC_REG_BITS;
	localparam int IMM_J_LSB = `DEC_RS1_LSB;

	opcode_t op;
	value_t  imm_i;
	value_t  imm_s;
	value_t  imm_j;

	assign op = get_opcode(instr);

	// An arithmetic shift of the whole word drops the low fields and
	// replicates bit 31 into the upper bits in one step
	assign imm_i = value_t'($signed(instr) >>> IMM_I_LSB);
	assign imm_s = value_t'($signed(instr) >>> IMM_S_LSB);
	assign imm_j = value_t'($signed(instr) >>> IMM_J_LSB);

	// ==========================================================================
	// Immediate select
	// ==========================================================================

	always_comb begin
		imm     = '0;
		has_imm = 1'b0;
		case (op)
			OP_ADDI, OP_LOAD: begin
				imm     = imm_i;
				has_imm = 1'b1;
			end
			OP_STORE: begin
				imm     = imm_s;
				has_imm = 1'b1;
			end
			// Branch and call targets are pc relative and wrap at XLEN bits
			OP_BEQ: begin
				imm     = pc + imm_s;
				has_imm = 1'b1;
			end
			OP_JSR: begin
				imm     = pc + imm_j;
				has_imm = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// ==== logic/decode_class.sv ====
// Operation class decoder; instantiated by the decode stage to flag the unit an opcode needs
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_class import isa_pkg::*; import decode_pkg::*; (
	input  instr_t    instr,
	output op_class_t op_class,
	output logic      nop,
	output logic      implemented
);

	opcode_t op;

	assign op = get_opcode(instr);

	// ==========================================================================
	// Opcode to class map
	// ==========================================================================

	always_comb begin
		op_class    = CLS_NONE;
		nop         = 1'b0;
		implemented = 1'b1;
		case (op)
			// NOP claims no execution unit at all
			OP_NOP: nop = 1'b1;
			OP_ADD, OP_ADDI, OP_AND, OP_OR: begin
				op_class[`DEC_CLS_ALU] = 1'b1;
			end
			OP_MUL: op_class[`DEC_CLS_MUL] = 1'b1;
			OP_DIV: op_class[`DEC_CLS_DIV] = 1'b1;
			// Loads and stores also raise MEM so the memory pipe can steer on one bit
			OP_LOAD: begin
				op_class[`DEC_CLS_LOAD] = 1'b1;
				op_class[`DEC_CLS_MEM]  = 1'b1;
			end
			OP_STORE: begin
				op_class[`DEC_CLS_STORE] = 1'b1;
				op_class[`DEC_CLS_MEM]   = 1'b1;
			end
			OP_BEQ:   op_class[`DEC_CLS_BRANCH] = 1'b1;
			OP_JSR:   op_class[`DEC_CLS_JUMP]   = 1'b1;
			OP_CSR:   op_class[`DEC_CLS_CSR]    = 1'b1;
			OP_FENCE: op_class[`DEC_CLS_FENCE]  = 1'b1;
			OP_SYS:   op_class[`DEC_CLS_SYS]    = 1'b1;
			// Undefined opcodes leave the class vector empty
			default:  implemented = 1'b0;
		endcase
	end

	// Every real instruction goes to exactly one primary unit, and an
	// undefined opcode claims none, so issue never sees a conflict
	a_one_class: assert final (
		(implemented && !nop) ? $onehot(op_class & ~CLS_MEM_MASK)
		                      : (op_class == CLS_NONE))
		else $error("decode_class: class vector 0x%0h for opcode %0d", op_class, op);

endmodule

// ==== logic/insn_decoder.sv ====
// Decode stage top level; takes a fetched instruction and registers its decode under the enable
`timescale 1ns/1ps

module insn_decoder import isa_pkg::*; import decode_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      en,
	input  logic      instr_valid,
	input  instr_t    instr,
	input  value_t    pc,
	input  op_mode_t  mode,
	output logic      dec_valid,
	output logic      nop,
	output reg_num_t  rd,
	output reg_num_t  rs1,
	output reg_num_t  rs2,
	output logic      has_rd,
	output logic      has_rs1,
	output logic      has_rs2,
	output logic      rd_z,
	output logic      rs1_z,
	output logic      rs2_z,
	output value_t    imm,
	output logic      has_imm,
	output op_class_t op_class,
	output cause_t    cause
);

	value_t    dec_imm;
	logic      dec_has_imm;
	op_class_t dec_class;
	logic      dec_nop;
	logic      dec_impl;
	cause_t    dec_cause;

	reg_fields_if u_regs_if ();

	// ==========================================================================
	// Combinational decoders, all working on the raw instruction bits
	// ==========================================================================

	decode_regs u_regs (
		.instr (instr),
		.mode  (mode),
		.regs  (u_regs_if.source)
	);

	decode_imm u_imm (
		.instr   (instr),
		.pc      (pc),
		.imm     (dec_imm),
		.has_imm (dec_has_imm)
	);

	decode_class u_class (
		.instr       (instr),
		.op_class    (dec_class),
		.nop         (dec_nop),
		.implemented (dec_impl)
	);

	// Fault priority. An unimplemented opcode hides any register fault
	always_comb begin
		if (!dec_impl)
			dec_cause = FLT_UNIMP;
		else if (u_regs_if.bad_reg)
			dec_cause = FLT_BADREG;
		else
			dec_cause = FLT_NONE;
	end

	// ==========================================================================
	// Output register
	// ==========================================================================

	// Reset and bubbles both leave a nop that reads nothing.
	// With en low every field holds, which is how the next stage stalls us
	always_ff @(posedge clk) begin
		if (rst || (en && !instr_valid)) begin
			dec_valid <= 1'b0;
			nop       <= 1'b1;
			rd        <= '0;
			rs1       <= '0;
			rs2       <= '0;
			has_rd    <= 1'b0;
			has_rs1   <= 1'b0;
			has_rs2   <= 1'b0;
			rd_z      <= 1'b1;
			// After reset only rd_z is set; a bubble marks all fields as zero
			rs1_z     <= !rst;
			rs2_z     <= !rst;
			imm       <= '0;
			has_imm   <= 1'b0;
			op_class  <= CLS_NONE;
			cause     <= FLT_NONE;
		end else if (en) begin
			dec_valid <= 1'b1;
			nop       <= dec_nop;
			rd        <= u_regs_if.rd;
			rs1       <= u_regs_if.rs1;
			rs2       <= u_regs_if.rs2;
			has_rd    <= u_regs_if.has_rd;
			has_rs1   <= u_regs_if.has_rs1;
			has_rs2   <= u_regs_if.has_rs2;
			rd_z      <= u_regs_if.rd_z;
			rs1_z     <= u_regs_if.rs1_z;
			rs2_z     <= u_regs_if.rs2_z;
			imm       <= dec_imm;
			has_imm   <= dec_has_imm;
			op_class  <= dec_class;
			cause     <= dec_cause;
		end
	end

	// A slot that is not valid must never carry a fault to the trap logic
	a_bubble_no_fault: assert property (@(posedge clk) disable iff (rst)
		!dec_valid |-> cause == FLT_NONE)
		else $error("insn_decoder: fault cause %0d on an invalid slot", cause);

endmodule

// ==== dv/decode_model.svh ====
// Reference model of the decode stage, included into the testbench module to predict its outputs
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected value of every registered output of the stage
typedef struct packed {
	logic      dec_valid;
	logic      nop;
	reg_num_t  rd;
	reg_num_t  rs1;
	reg_num_t  rs2;
	logic      has_rd;
	logic      has_rs1;
	logic      has_rs2;
	logic      rd_z;
	logic      rs1_z;
	logic      rs2_z;
	value_t    imm;
	logic      has_imm;
	op_class_t op_class;
	cause_t    cause;
} dec_expect_t;

// Straight out of reset only nop and rd_z are high
function automatic dec_expect_t reset_expect();
	dec_expect_t e;
	e = '0;
	e.nop = 1'b1;
	e.rd_z = 1'b1;
	return e;
endfunction

// Decode of one instruction as the toy ISA defines it, or the bubble when v is low
function automatic dec_expect_t model_decode(input instr_t w, input value_t p,
		input op_mode_t m, input logic v);
	dec_expect_t e;
	logic [5:0]  opc;
	logic        use_rd;
	logic        use_rs1;
	logic        use_rs2;
	logic        bad;
	e = reset_expect();
	// A bubble reads nothing, so every register field reads as zero
	e.rs1_z = 1'b1;
	e.rs2_z = 1'b1;
	if (!v)
		return e;
	opc = w[5:0];
	e.dec_valid = 1'b1;
	e.nop = (opc == 6'd0);
	// ALU, MUL, DIV and LOAD use rd; JSR and CSR too
	use_rd  = opc inside {[6'd1:6'd7], 6'd10, 6'd11};
	use_rs1 = opc inside {[6'd1:6'd9], 6'd11};
	use_rs2 = opc inside {6'd1, [6'd3:6'd6], 6'd8, 6'd9};
	e.rd      = use_rd  ? w[11:6]  : 6'd0;
	e.rs1     = use_rs1 ? w[17:12] : 6'd0;
	e.rs2     = use_rs2 ? w[23:18] : 6'd0;
	e.has_rd  = use_rd;
	e.has_rs1 = use_rs1;
	e.has_rs2 = use_rs2;
	e.rd_z    = (e.rd == 6'd0);
	e.rs1_z   = (e.rs1 == 6'd0);
	e.rs2_z   = (e.rs2 == 6'd0);
	// Registers 56 and up belong to machine mode
	bad = (m == MODE_USER) && (e.rd >= 6'd56 || e.rs1 >= 6'd56 || e.rs2 >= 6'd56);
	e.has_imm = opc inside {6'd2, [6'd7:6'd10]};
	case (opc)
		6'd1, 6'd3, 6'd4: e.op_class[`DEC_CLS_ALU] = 1'b1;
		6'd2: begin
			e.op_class[`DEC_CLS_ALU] = 1'b1;
			e.imm = {{18{w[31]}}, w[31:18]};
		end
		6'd5: e.op_class[`DEC_CLS_MUL] = 1'b1;
		6'd6: e.op_class[`DEC_CLS_DIV] = 1'b1;
		6'd7: begin
			e.op_class[`DEC_CLS_LOAD] = 1'b1;
			e.op_class[`DEC_CLS_MEM]  = 1'b1;
			e.imm = {{18{w[31]}}, w[31:18]};
		end
		6'd8: begin
			e.op_class[`DEC_CLS_STORE] = 1'b1;
			e.op_class[`DEC_CLS_MEM]   = 1'b1;
			e.imm = {{24{w[31]}}, w[31:24]};
		end
		// Targets wrap at 32 bits like any adder would
		6'd9: begin
			e.op_class[`DEC_CLS_BRANCH] = 1'b1;
			e.imm = p + {{24{w[31]}}, w[31:24]};
		end
		6'd10: begin
			e.op_class[`DEC_CLS_JUMP] = 1'b1;
			e.imm = p + {{12{w[31]}}, w[31:12]};
		end
		6'd11: e.op_class[`DEC_CLS_CSR]   = 1'b1;
		6'd12: e.op_class[`DEC_CLS_FENCE] = 1'b1;
		6'd13: e.op_class[`DEC_CLS_SYS]   = 1'b1;
		default: ;
	endcase
	if (opc > 6'd13)
		e.cause = FLT_UNIMP;
	else if (bad)
		e.cause = FLT_BADREG;
	else
		e.cause = FLT_NONE;
	return e;
endfunction

`endif

// ==== dv/tb_insn_decoder.sv ====
// Directed testbench for the decode stage; build with the file list, tb_insn_decoder is the top
`timescale 1ns/1ps
`include "decode_params.svh"

module tb_insn_decoder import isa_pkg::*; import decode_pkg::*; ();

	// Cycles spent by each test. The watchdog allows twice their sum
	localparam int RESET_CYCLES   = 7;
	localparam int IMPL_CYCLES    = 29;
	localparam int FAULT_CYCLES   = 63;
	localparam int BUBBLE_CYCLES  = 17;
	localparam int STALL_CYCLES   = 10;
	localparam int TARGET_CYCLES  = 17;
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + IMPL_CYCLES + FAULT_CYCLES
		+ BUBBLE_CYCLES + STALL_CYCLES + TARGET_CYCLES);

	logic        clk;
	logic        rst;
	logic        en;
	logic        instr_valid;
	instr_t      instr;
	value_t      pc;
	op_mode_t    mode;
	logic        dec_valid;
	logic        nop;
	reg_num_t    rd;
	reg_num_t    rs1;
	reg_num_t    rs2;
	logic        has_rd;
	logic        has_rs1;
	logic        has_rs2;
	logic        rd_z;
	logic        rs1_z;
	logic        rs2_z;
	value_t      imm;
	logic        has_imm;
	op_class_t   op_class;
	cause_t      cause;

	`include "decode_model.svh"

	// Model of the output register, updated at each rising edge
	dec_expect_t cur_exp;
	logic        exp_known = 1'b0;
	logic        rst_next = 1'b1;
	logic [31:0] rng_state = 32'haf2553c6;
	int          err_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;

	insn_decoder u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	function automatic logic [31:0] rand_word();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("FAILED %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_outputs(input dec_expect_t e);
		check_value("dec_valid", 32'(dec_valid), 32'(e.dec_valid));
		check_value("nop", 32'(nop), 32'(e.nop));
		check_value("rd", 32'(rd), 32'(e.rd));
		check_value("rs1", 32'(rs1), 32'(e.rs1));
		check_value("rs2", 32'(rs2), 32'(e.rs2));
		check_value("has_rd", 32'(has_rd), 32'(e.has_rd));
		check_value("has_rs1", 32'(has_rs1), 32'(e.has_rs1));
		check_value("has_rs2", 32'(has_rs2), 32'(e.has_rs2));
		check_value("rd_z", 32'(rd_z), 32'(e.rd_z));
		check_value("rs1_z", 32'(rs1_z), 32'(e.rs1_z));
		check_value("rs2_z", 32'(rs2_z), 32'(e.rs2_z));
		check_value("imm", imm, e.imm);
		check_value("has_imm", 32'(has_imm), 32'(e.has_imm));
		check_value("op_class", 32'(op_class), 32'(e.op_class));
		check_value("cause", 32'(cause), 32'(e.cause));
	endtask

	// ==========================================================================
	// One clock step. The edge takes the inputs driven a cycle ago, so the
	// model is advanced first, then new inputs go out and the outputs are
	// compared at the falling edge where they are settled
	// ==========================================================================

	task automatic step(input logic e, input logic v, input instr_t w, input value_t p,
			input op_mode_t m);
		@(posedge clk);
		if (rst) begin
			cur_exp = reset_expect();
			exp_known = 1'b1;
		end else if (en) begin
			cur_exp = model_decode(instr, pc, mode, instr_valid);
		end
		rst         <= rst_next;
		en          <= e;
		instr_valid <= v;
		instr       <= w;
		pc          <= p;
		mode        <= m;
		@(negedge clk);
		if (exp_known)
			check_outputs(cur_exp);
	endtask

	// Stalls for one edge, which also checks the last enabled decode
	task automatic idle();
		step(1'b0, 1'b0, '0, '0, MODE_USER);
	endtask

	task automatic issue_regs(input logic [5:0] op, input reg_num_t r_d, input reg_num_t r_s1,
			input reg_num_t r_s2, input op_mode_t m);
		logic [31:0] r;
		r = rand_word();
		step(1'b1, 1'b1, {r[31:24], r_s2, r_s1, r_d, op}, r, m);
	endtask

	task automatic issue_target(input logic [5:0] op, input logic [19:0] hi, input value_t p);
		instr_t w;
		w = rand_word();
		w[31:12] = hi;
		w[5:0] = op;
		step(1'b1, 1'b1, w, p, MODE_MACHINE);
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		$display("test %-12s done, %0d errors", name, err_count - errs_at_start);
	endtask

	// ==========================================================================
	// Directed tests
	// ==========================================================================

	task automatic reset_values();
		int start;
		start = err_count;
		// Five edges in reset, released by the last one
		for (int i = 0; i < 5; i++) begin
			rst_next = (i < 4);
			step(1'b0, 1'b0, '0, '0, MODE_USER);
		end
		step(1'b0, 1'b1, rand_word(), rand_word(), MODE_MACHINE);
		step(1'b0, 1'b0, '0, '0, MODE_USER);
		finish_test("reset", start);
	endtask

	task automatic implemented_opcodes();
		int     start;
		instr_t w;
		start = err_count;
		for (int round = 0; round < 2; round++) begin
			for (int op = 0; op < 14; op++) begin
				w = rand_word();
				w[5:0] = 6'(op);
				step(1'b1, 1'b1, w, rand_word(), MODE_MACHINE);
			end
		end
		idle();
		finish_test("implemented", start);
	endtask

	task automatic fault_causes();
		int     start;
		instr_t w;
		start = err_count;
		for (int op = 14; op < 64; op++) begin
			w = rand_word();
			w[5:0] = 6'(op);
			step(1'b1, 1'b1, w, rand_word(), op_mode_t'(op[0]));
		end
		issue_regs(OP_ADD, 6'd56, 6'd1, 6'd2, MODE_USER);
		issue_regs(OP_ADD, 6'd56, 6'd1, 6'd2, MODE_MACHINE);
		issue_regs(OP_LOAD, 6'd3, 6'd63, 6'd0, MODE_USER);
		issue_regs(OP_LOAD, 6'd3, 6'd63, 6'd0, MODE_MACHINE);
		issue_regs(OP_STORE, 6'd0, 6'd4, 6'd60, MODE_USER);
		issue_regs(OP_STORE, 6'd0, 6'd4, 6'd60, MODE_MACHINE);
		issue_regs(OP_JSR, 6'd57, 6'd0, 6'd0, MODE_USER);
		// Privileged numbers in fields the opcode ignores are harmless
		issue_regs(OP_JSR, 6'd5, 6'd60, 6'd61, MODE_USER);
		issue_regs(OP_NOP, 6'd60, 6'd61, 6'd62, MODE_USER);
		issue_regs(OP_ADD, 6'd55, 6'd55, 6'd55, MODE_USER);
		// Unimplemented outranks the register fault
		issue_regs(6'd40, 6'd60, 6'd61, 6'd0, MODE_USER);
		issue_regs(6'd63, 6'd0, 6'd0, 6'd62, MODE_USER);
		idle();
		finish_test("faults", start);
	endtask

	task automatic bubble_slots();
		int     start;
		instr_t w;
		start = err_count;
		// Every fourth slot is valid, so bubbles sit between real decodes
		for (int i = 0; i < 16; i++) begin
			w = rand_word();
			w[5:0] = 6'(i * 4);
			step(1'b1, (i % 4 == 3), w, rand_word(), op_mode_t'(w[31]));
		end
		idle();
		finish_test("bubbles", start);
	endtask

	task automatic stall_hold();
		int     start;
		instr_t w;
		start = err_count;
		w = rand_word();
		w[5:0] = OP_MUL;
		step(1'b1, 1'b1, w, rand_word(), MODE_MACHINE);
		for (int i = 0; i < 4; i++)
			step(1'b0, i[0], rand_word(), rand_word(), op_mode_t'(i[1]));
		w = rand_word();
		w[5:0] = OP_LOAD;
		step(1'b1, 1'b1, w, rand_word(), MODE_MACHINE);
		// A bubble held under stall stays a bubble
		step(1'b1, 1'b0, rand_word(), rand_word(), MODE_USER);
		step(1'b0, 1'b1, rand_word(), rand_word(), MODE_MACHINE);
		step(1'b0, 1'b1, rand_word(), rand_word(), MODE_MACHINE);
		idle();
		finish_test("stall", start);
	endtask

	task automatic pc_targets();
		int          start;
		logic [31:0] r;
		start = err_count;
		// Ends of the offset ranges, and pcs chosen so the sum wraps
		issue_target(OP_BEQ, 20'h80000, rand_word());
		issue_target(OP_BEQ, 20'h7f000, rand_word());
		issue_target(OP_BEQ, 20'hff000, 32'h0000_0000);
		issue_target(OP_BEQ, 20'h01000, 32'hffff_ffff);
		issue_target(OP_JSR, 20'h80000, rand_word());
		issue_target(OP_JSR, 20'h7ffff, rand_word());
		issue_target(OP_JSR, 20'hfffff, 32'h0000_0000);
		issue_target(OP_JSR, 20'h00010, 32'hffff_fff8);
		for (int i = 0; i < 8; i++) begin
			r = rand_word();
			issue_target(i[0] ? OP_JSR : OP_BEQ, r[31:12], rand_word());
		end
		idle();
		finish_test("targets", start);
	endtask

	initial begin
		rst         <= 1'b1;
		en          <= 1'b0;
		instr_valid <= 1'b0;
		instr       <= '0;
		pc          <= '0;
		mode        <= MODE_USER;
		reset_values();
		implemented_opcodes();
		fault_causes();
		bubble_slots();
		stall_hold();
		pc_targets();
		$display("Summary: %0d checks, %0d errors", check_count, err_count);
		if (err_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== pipe_decode.f ====
+incdir+logic
+incdir+dv
logic/isa_pkg.sv
logic/decode_pkg.sv
logic/reg_fields_if.sv
logic/decode_regs.sv
logic/decode_imm.sv
logic/decode_class.sv
logic/insn_decoder.sv
dv/tb_insn_decoder.sv

// ==== Makefile ====
TOP := tb_insn_decoder
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): pipe_decode.f $(wildcard logic/*.sv logic/*.svh dv/*.sv dv/*.svh)
	verilator --binary --timing --assert -f pipe_decode.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing -f pipe_decode.f --top-module $(TOP)
	verilator --lint-only -Ilogic logic/isa_pkg.sv logic/decode_pkg.sv \
		logic/reg_fields_if.sv logic/decode_regs.sv logic/decode_imm.sv \
		logic/decode_class.sv logic/insn_decoder.sv --top-module insn_decoder

clean:
	rm -rf obj_dir $(LOG)
